// File: verilog/rv_core_config.svh
// widths, reset pc, opcode and funct3 codes of the core
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

`define RV_XLEN      32
`define RV_REGS      32
`define RV_RESET_PC  32'h0000_0000

`define RV_OP_REG    7'b0110011
`define RV_OP_IMM    7'b0010011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011
`define RV_OP_JAL    7'b1101111

`define RV_F3_ADD    3'b000
`define RV_F3_SLT    3'b010
`define RV_F3_OR     3'b110
`define RV_F3_AND    3'b111
`define RV_F3_BEQ    3'b000
`define RV_F3_BNE    3'b001

`endif

// File: verilog/rv_core_pkg.sv
// instruction union, control struct, alu and forwarding enums, pipeline register structs
`include "rv_core_config.svh"

package rv_core_pkg;

	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [$clog2(`RV_REGS)-1:0] reg_idx_t;

	// ----------------------------------------
	// instruction formats
	// ----------------------------------------
	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		reg_idx_t    rs1;
		logic [2:0]  funct3;
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	// branches reuse this layout
	typedef struct packed {
		logic [6:0] imm_hi;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		reg_idx_t   rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		j_fmt_t j_fmt;
	} instr_u;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_op_e;

	// same order as the forwarding codes of the older core
	typedef enum logic [1:0] {
		FWD_RF  = 2'b00,
		FWD_WB  = 2'b01,
		FWD_MEM = 2'b10,
		FWD_EX  = 2'b11
	} fwd_sel_e;

	typedef struct packed {
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    alu_src;
		logic    is_jal;
		alu_op_e alu_op;
	} ctrl_t;

	// ----------------------------------------
	// pipeline registers
	// ----------------------------------------
	typedef struct packed {
		ctrl_t    ctrl;
		reg_idx_t rs1_idx;
		reg_idx_t rs2_idx;
		reg_idx_t rd;
		word_t    rs1_val;
		word_t    rs2_val;
		word_t    imm;
		word_t    link;
	} id_ex_t;

	typedef struct packed {
		ctrl_t    ctrl;
		reg_idx_t rd;
		word_t    alu_result;
		word_t    store_data;
		word_t    link;
	} ex_mem_t;

	typedef struct packed {
		ctrl_t    ctrl;
		reg_idx_t rd;
		word_t    alu_result;
		word_t    load_data;
		word_t    link;
	} mem_wb_t;

endpackage

// File: verilog/reg_file.sv
// register file, x0 tied to zero, write-through on same-cycle read
`include "rv_core_config.svh"

module reg_file (
	input  logic                  clk,
	input  logic                  rst_n,
	input  rv_core_pkg::reg_idx_t rs1_idx,
	input  rv_core_pkg::reg_idx_t rs2_idx,
	input  logic                  wr_en,
	input  rv_core_pkg::reg_idx_t wr_idx,
	input  rv_core_pkg::word_t    wr_data,
	output rv_core_pkg::word_t    rs1_data,
	output rv_core_pkg::word_t    rs2_data
);

	rv_core_pkg::word_t regs [`RV_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			regs <= '{default: '0};
		end else if (wr_en && wr_idx != '0) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// writeback value bypasses the array in the same cycle
	always_comb begin
		if (rs1_idx == '0)
			rs1_data = '0;
		else if (wr_en && wr_idx == rs1_idx)
			rs1_data = wr_data;
		else
			rs1_data = regs[rs1_idx];
		if (rs2_idx == '0)
			rs2_data = '0;
		else if (wr_en && wr_idx == rs2_idx)
			rs2_data = wr_data;
		else
			rs2_data = regs[rs2_idx];
	end

endmodule

// File: verilog/decode_stage.sv
// main decoder, immediate generator, branch compare and redirect target
`include "rv_core_config.svh"

module decode_stage (
	input  rv_core_pkg::instr_u   instr,
	input  rv_core_pkg::word_t    pc,
	input  rv_core_pkg::word_t    rs1_data,
	input  rv_core_pkg::word_t    rs2_data,
	input  rv_core_pkg::fwd_sel_e fwd_a,
	input  rv_core_pkg::fwd_sel_e fwd_b,
	input  rv_core_pkg::word_t    ex_result,
	input  rv_core_pkg::word_t    mem_result,
	input  rv_core_pkg::word_t    wb_result,
	output rv_core_pkg::ctrl_t    ctrl,
	output rv_core_pkg::word_t    imm,
	output rv_core_pkg::word_t    target,
	output logic                  redirect
);

	rv_core_pkg::alu_op_e f3_op;
	rv_core_pkg::word_t   cmp_a;
	rv_core_pkg::word_t   cmp_b;
	logic                 is_branch;
	logic                 is_jal;
	logic                 taken;

	// ----------------------------------------
	// control
	// ----------------------------------------
	always_comb begin
		case (instr.r_fmt.funct3)
			`RV_F3_SLT: f3_op = rv_core_pkg::ALU_SLT;
			`RV_F3_OR:  f3_op = rv_core_pkg::ALU_OR;
			`RV_F3_AND: f3_op = rv_core_pkg::ALU_AND;
			default:    f3_op = rv_core_pkg::ALU_ADD;
		endcase
	end

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = rv_core_pkg::ALU_ADD;
		case (instr.r_fmt.opcode)
			`RV_OP_REG: begin
				ctrl.reg_write = 1'b1;
				// funct7 bit 5 turns add into sub
				if (instr.r_fmt.funct3 == `RV_F3_ADD && instr.r_fmt.funct7[5])
					ctrl.alu_op = rv_core_pkg::ALU_SUB;
				else
					ctrl.alu_op = f3_op;
			end
			`RV_OP_IMM: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src   = 1'b1;
				ctrl.alu_op    = f3_op;
			end
			`RV_OP_LOAD: begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_read  = 1'b1;
				ctrl.alu_src   = 1'b1;
			end
			`RV_OP_STORE: begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_src   = 1'b1;
			end
			`RV_OP_JAL: begin
				ctrl.reg_write = 1'b1;
				ctrl.is_jal    = 1'b1;
			end
			default: ;
		endcase
	end

	// ----------------------------------------
	// immediates
	// ----------------------------------------
	always_comb begin
		case (instr.r_fmt.opcode)
			`RV_OP_IMM, `RV_OP_LOAD:
				imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
			`RV_OP_STORE:
				imm = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
			`RV_OP_BRANCH:
				imm = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_lo[0],
					instr.s_fmt.imm_hi[5:0], instr.s_fmt.imm_lo[4:1], 1'b0};
			`RV_OP_JAL:
				imm = {{12{instr.j_fmt.imm_20}}, instr.j_fmt.imm_19_12,
					instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
			default:
				imm = '0;
		endcase
	end

	// branch operands, youngest producer first
	always_comb begin
		case (fwd_a)
			rv_core_pkg::FWD_EX:  cmp_a = ex_result;
			rv_core_pkg::FWD_MEM: cmp_a = mem_result;
			rv_core_pkg::FWD_WB:  cmp_a = wb_result;
			default:              cmp_a = rs1_data;
		endcase
		case (fwd_b)
			rv_core_pkg::FWD_EX:  cmp_b = ex_result;
			rv_core_pkg::FWD_MEM: cmp_b = mem_result;
			rv_core_pkg::FWD_WB:  cmp_b = wb_result;
			default:              cmp_b = rs2_data;
		endcase
	end

	assign is_branch = instr.s_fmt.opcode == `RV_OP_BRANCH;
	assign is_jal    = instr.j_fmt.opcode == `RV_OP_JAL;
	assign taken     = is_branch &&
		((instr.s_fmt.funct3 == `RV_F3_BEQ && cmp_a == cmp_b) ||
		 (instr.s_fmt.funct3 == `RV_F3_BNE && cmp_a != cmp_b));

	assign target   = pc + imm;
	assign redirect = taken || is_jal;

endmodule

// File: verilog/hazard_forward.sv
// forwarding selects for decode and execute, load-use stall, redirect flush
module hazard_forward (
	input  rv_core_pkg::reg_idx_t  rs1_id,
	input  rv_core_pkg::reg_idx_t  rs2_id,
	input  logic                   uses_rs1,
	input  logic                   uses_rs2,
	input  logic                   is_branch,
	input  rv_core_pkg::id_ex_t    id_ex,
	input  rv_core_pkg::ex_mem_t   ex_mem,
	input  rv_core_pkg::mem_wb_t   mem_wb,
	input  logic                   redirect,
	output rv_core_pkg::fwd_sel_e  fwd_id_a,
	output rv_core_pkg::fwd_sel_e  fwd_id_b,
	output rv_core_pkg::fwd_sel_e  fwd_ex_a,
	output rv_core_pkg::fwd_sel_e  fwd_ex_b,
	output logic                   stall,
	output logic                   flush
);

	logic load_use_ex;
	logic load_branch_mem;

	// youngest writer of src wins, x0 never forwards
	function automatic rv_core_pkg::fwd_sel_e pick_src(
		input rv_core_pkg::reg_idx_t src,
		input logic                  from_ex
	);
		rv_core_pkg::fwd_sel_e sel;
		sel = rv_core_pkg::FWD_RF;
		if (src != '0) begin
			if (from_ex && id_ex.ctrl.reg_write && id_ex.rd == src)
				sel = rv_core_pkg::FWD_EX;
			else if (ex_mem.ctrl.reg_write && ex_mem.rd == src)
				sel = rv_core_pkg::FWD_MEM;
			else if (mem_wb.ctrl.reg_write && mem_wb.rd == src)
				sel = rv_core_pkg::FWD_WB;
		end
		return sel;
	endfunction

	always_comb begin
		fwd_id_a = pick_src(rs1_id, 1'b1);
		fwd_id_b = pick_src(rs2_id, 1'b1);
		fwd_ex_a = pick_src(id_ex.rs1_idx, 1'b0);
		fwd_ex_b = pick_src(id_ex.rs2_idx, 1'b0);
	end

	// load in execute, any consumer in decode
	assign load_use_ex = id_ex.ctrl.mem_read && id_ex.rd != '0 &&
		((uses_rs1 && rs1_id == id_ex.rd) || (uses_rs2 && rs2_id == id_ex.rd));

	// branch waits until the load is in writeback
	assign load_branch_mem = is_branch && ex_mem.ctrl.mem_read && ex_mem.rd != '0 &&
		(rs1_id == ex_mem.rd || rs2_id == ex_mem.rd);

	assign stall = load_use_ex || load_branch_mem;
	assign flush = redirect && !stall;

endmodule

// File: verilog/execute_stage.sv
// execute forwarding muxes, operand select and alu
`include "rv_core_config.svh"

module execute_stage (
	input  rv_core_pkg::id_ex_t   id_ex,
	input  rv_core_pkg::fwd_sel_e fwd_a,
	input  rv_core_pkg::fwd_sel_e fwd_b,
	input  rv_core_pkg::word_t    mem_result,
	input  rv_core_pkg::word_t    wb_result,
	output rv_core_pkg::word_t    result,
	output rv_core_pkg::word_t    store_data
);

	rv_core_pkg::word_t op_a;
	rv_core_pkg::word_t op_b;

	// execute only sees memory and writeback producers
	always_comb begin
		case (fwd_a)
			rv_core_pkg::FWD_MEM: op_a = mem_result;
			rv_core_pkg::FWD_WB:  op_a = wb_result;
			default:              op_a = id_ex.rs1_val;
		endcase
		case (fwd_b)
			rv_core_pkg::FWD_MEM: store_data = mem_result;
			rv_core_pkg::FWD_WB:  store_data = wb_result;
			default:              store_data = id_ex.rs2_val;
		endcase
	end

	assign op_b = id_ex.ctrl.alu_src ? id_ex.imm : store_data;

	always_comb begin
		case (id_ex.ctrl.alu_op)
			rv_core_pkg::ALU_SUB: result = op_a - op_b;
			rv_core_pkg::ALU_AND: result = op_a & op_b;
			rv_core_pkg::ALU_OR:  result = op_a | op_b;
			rv_core_pkg::ALU_SLT:
				result = {{(`RV_XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
			default:              result = op_a + op_b;
		endcase
	end

endmodule

// File: verilog/rv_core.sv
// five-stage core top: pc, pipeline registers, memory ports, writeback select
`include "rv_core_config.svh"

module rv_core (
	input  logic                     clk,
	input  logic                     rst_n,
	output logic [`RV_XLEN-3:0]      imem_addr,
	input  rv_core_pkg::word_t       imem_rdata,
	output logic                     dmem_re,
	output logic                     dmem_we,
	output rv_core_pkg::word_t       dmem_addr,
	output rv_core_pkg::word_t       dmem_wdata,
	input  rv_core_pkg::word_t       dmem_rdata
);

	rv_core_pkg::word_t    pc;
	rv_core_pkg::word_t    pc_next;
	rv_core_pkg::instr_u   ifid_instr;
	rv_core_pkg::word_t    ifid_pc;
	rv_core_pkg::id_ex_t   id_ex;
	rv_core_pkg::id_ex_t   id_ex_next;
	rv_core_pkg::ex_mem_t  ex_mem;
	rv_core_pkg::mem_wb_t  mem_wb;

	rv_core_pkg::word_t    rs1_data;
	rv_core_pkg::word_t    rs2_data;
	rv_core_pkg::ctrl_t    dec_ctrl;
	rv_core_pkg::word_t    dec_imm;
	rv_core_pkg::word_t    dec_target;
	logic                  dec_redirect;
	rv_core_pkg::fwd_sel_e fwd_id_a;
	rv_core_pkg::fwd_sel_e fwd_id_b;
	rv_core_pkg::fwd_sel_e fwd_ex_a;
	rv_core_pkg::fwd_sel_e fwd_ex_b;
	logic                  stall;
	logic                  flush;
	logic                  uses_rs1;
	logic                  uses_rs2;
	logic                  is_branch;

	rv_core_pkg::word_t    ex_result;
	rv_core_pkg::word_t    ex_store_data;
	rv_core_pkg::word_t    ex_fwd;
	rv_core_pkg::word_t    mem_fwd;
	rv_core_pkg::word_t    wb_result;

	// ----------------------------------------
	// fetch
	// ----------------------------------------
	assign pc_next   = stall ? pc : (flush ? dec_target : pc + `RV_XLEN'(4));
	assign imem_addr = pc[`RV_XLEN-1:2];

	always_ff @(posedge clk) begin
		if (!rst_n)
			pc <= `RV_RESET_PC;
		else
			pc <= pc_next;
	end

	// flush leaves an all-zero word, which decodes to no control
	always_ff @(posedge clk) begin
		if (!stall) begin
			ifid_instr <= flush ? '0 : imem_rdata;
			ifid_pc    <= pc;
		end
		if (!rst_n)
			ifid_instr <= '0;
	end

	// ----------------------------------------
	// decode
	// ----------------------------------------
	assign is_branch = ifid_instr.r_fmt.opcode == `RV_OP_BRANCH;
	assign uses_rs2  = is_branch || ifid_instr.r_fmt.opcode == `RV_OP_REG ||
		ifid_instr.r_fmt.opcode == `RV_OP_STORE;
	assign uses_rs1  = uses_rs2 || ifid_instr.r_fmt.opcode == `RV_OP_IMM ||
		ifid_instr.r_fmt.opcode == `RV_OP_LOAD;

	reg_file u_reg_file (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1_idx  (ifid_instr.r_fmt.rs1),
		.rs2_idx  (ifid_instr.r_fmt.rs2),
		.wr_en    (mem_wb.ctrl.reg_write),
		.wr_idx   (mem_wb.rd),
		.wr_data  (wb_result),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data)
	);

	decode_stage u_decode (
		.instr      (ifid_instr),
		.pc         (ifid_pc),
		.rs1_data   (rs1_data),
		.rs2_data   (rs2_data),
		.fwd_a      (fwd_id_a),
		.fwd_b      (fwd_id_b),
		.ex_result  (ex_fwd),
		.mem_result (mem_fwd),
		.wb_result  (wb_result),
		.ctrl       (dec_ctrl),
		.imm        (dec_imm),
		.target     (dec_target),
		.redirect   (dec_redirect)
	);

	hazard_forward u_hazard (
		.rs1_id    (ifid_instr.r_fmt.rs1),
		.rs2_id    (ifid_instr.r_fmt.rs2),
		.uses_rs1  (uses_rs1),
		.uses_rs2  (uses_rs2),
		.is_branch (is_branch),
		.id_ex     (id_ex),
		.ex_mem    (ex_mem),
		.mem_wb    (mem_wb),
		.redirect  (dec_redirect),
		.fwd_id_a  (fwd_id_a),
		.fwd_id_b  (fwd_id_b),
		.fwd_ex_a  (fwd_ex_a),
		.fwd_ex_b  (fwd_ex_b),
		.stall     (stall),
		.flush     (flush)
	);

	// a stall turns the decode slot into a bubble
	always_comb begin
		id_ex_next.ctrl    = stall ? '0 : dec_ctrl;
		id_ex_next.rs1_idx = ifid_instr.r_fmt.rs1;
		id_ex_next.rs2_idx = ifid_instr.r_fmt.rs2;
		id_ex_next.rd      = ifid_instr.r_fmt.rd;
		id_ex_next.rs1_val = rs1_data;
		id_ex_next.rs2_val = rs2_data;
		id_ex_next.imm     = dec_imm;
		id_ex_next.link    = ifid_pc + `RV_XLEN'(4);
	end

	// ----------------------------------------
	// execute, memory, writeback
	// ----------------------------------------
	execute_stage u_execute (
		.id_ex      (id_ex),
		.fwd_a      (fwd_ex_a),
		.fwd_b      (fwd_ex_b),
		.mem_result (mem_fwd),
		.wb_result  (wb_result),
		.result     (ex_result),
		.store_data (ex_store_data)
	);

	// jal produces its link address, not an alu value
	assign ex_fwd  = id_ex.ctrl.is_jal ? id_ex.link : ex_result;
	assign mem_fwd = ex_mem.ctrl.is_jal ? ex_mem.link : ex_mem.alu_result;

	assign wb_result = mem_wb.ctrl.mem_read ? mem_wb.load_data :
		(mem_wb.ctrl.is_jal ? mem_wb.link : mem_wb.alu_result);

	always_ff @(posedge clk) begin
		id_ex             <= id_ex_next;
		ex_mem.ctrl       <= id_ex.ctrl;
		ex_mem.rd         <= id_ex.rd;
		ex_mem.alu_result <= ex_result;
		ex_mem.store_data <= ex_store_data;
		ex_mem.link       <= id_ex.link;
		mem_wb.ctrl       <= ex_mem.ctrl;
		mem_wb.rd         <= ex_mem.rd;
		mem_wb.alu_result <= ex_mem.alu_result;
		mem_wb.load_data  <= dmem_rdata;
		mem_wb.link       <= ex_mem.link;
		if (!rst_n) begin
			id_ex.ctrl  <= '0;
			ex_mem.ctrl <= '0;
			mem_wb.ctrl <= '0;
		end
	end

	assign dmem_re    = ex_mem.ctrl.mem_read;
	assign dmem_we    = ex_mem.ctrl.mem_write;
	assign dmem_addr  = ex_mem.alu_result;
	assign dmem_wdata = ex_mem.store_data;

endmodule

// File: verification/rv_core_checker.sv
// store checker: compares data port writes with the expected list, per-test lines and counts
module rv_core_checker (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               dmem_we,
	input  rv_core_pkg::word_t dmem_addr,
	input  rv_core_pkg::word_t dmem_wdata,
	input  rv_core_pkg::word_t done_addr,
	input  rv_core_pkg::word_t exp_addr [64],
	input  rv_core_pkg::word_t exp_data [64],
	input  int                 exp_count,
	input  int                 test_id,
	output logic               test_done,
	output int                 tests_passed,
	output int                 tests_failed,
	output int                 errors
);
	timeunit 1ns;
	timeprecision 1ns;

	int   idx = 0;
	int   test_errs = 0;
	int   n_pass = 0;
	int   n_fail = 0;
	int   n_err = 0;
	logic done_r = 1'b0;

	assign test_done    = done_r;
	assign tests_passed = n_pass;
	assign tests_failed = n_fail;
	assign errors       = n_err;

	task automatic note_error();
		test_errs++;
		n_err++;
	endtask

	task automatic close_test();
		if (test_errs == 0) begin
			n_pass++;
			$display("test %0d: pass, %0d stores checked", test_id, idx);
		end else begin
			n_fail++;
			$display("test %0d: fail, %0d errors", test_id, test_errs);
		end
		done_r = 1'b1;
	endtask

	// outputs are register driven, so the falling edge sees them settled
	always @(negedge clk) begin
		if (!rst_n) begin
			idx       = 0;
			test_errs = 0;
			done_r    = 1'b0;
		end else if (dmem_we) begin
			if (done_r || idx >= exp_count) begin
				$display("%0t: unexpected store of %h to address %h",
					$time, dmem_wdata, dmem_addr);
				note_error();
			end else if (dmem_addr == done_addr && idx < exp_count - 1) begin
				$display("%0t: test %0d finished with %0d expected stores missing",
					$time, test_id, exp_count - 1 - idx);
				note_error();
				close_test();
			end else begin
				if (dmem_addr != exp_addr[idx] || dmem_wdata != exp_data[idx]) begin
					$display("MISMATCH at %0t: store %0d wrote %h to %h, expected %h to %h",
						$time, idx, dmem_wdata, dmem_addr, exp_data[idx], exp_addr[idx]);
					note_error();
				end
				idx++;
				if (exp_addr[idx-1] == done_addr)
					close_test();
			end
		end
	end

endmodule

// File: verification/rv_core_props.sv
// concurrent assertions on the data port strobes and the pipeline stall, bound to rv_core
module rv_core_props (
	input logic clk,
	input logic rst_n,
	input logic dmem_we,
	input logic dmem_re,
	input logic stall
);
	timeunit 1ns;
	timeprecision 1ns;

	// one data port, so read and write never share a cycle
	data_port_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(dmem_we && dmem_re))
		else $error("data port read and write strobes high in the same cycle");

	// a branch on a load needs at most two bubbles
	stall_length: assert property (@(posedge clk) disable iff (!rst_n)
		(stall && $past(stall)) |-> !$past(stall, 2))
		else $error("pipeline stall held for more than two cycles");

	no_store_in_reset: assert property (@(posedge clk) !rst_n |=> !dmem_we)
		else $error("store strobe raised right after a reset cycle");

endmodule

bind rv_core rv_core_props props0 (
	.clk     (clk),
	.rst_n   (rst_n),
	.dmem_we (dmem_we),
	.dmem_re (dmem_re),
	.stall   (stall)
);

// File: verification/rv_core_tb.sv
// testbench top: clock, reset, memories, program builder, reference model, sequencing, watchdog
`include "rv_core_config.svh"

module rv_core_tb;
	timeunit 1ns;
	timeprecision 1ns;

	localparam int                 NUM_TESTS = 6;
	localparam rv_core_pkg::word_t DONE_ADDR = 32'h0000_0100;

	logic                       clk;
	logic                       rst_n = 1'b0;
	logic [`RV_XLEN-3:0]        imem_addr;
	rv_core_pkg::word_t         imem_rdata;
	logic                       dmem_re;
	logic                       dmem_we;
	rv_core_pkg::word_t         dmem_addr;
	rv_core_pkg::word_t         dmem_wdata;
	rv_core_pkg::word_t         dmem_rdata;

	rv_core_pkg::word_t imem [64];
	rv_core_pkg::word_t dmem [64];
	rv_core_pkg::word_t exp_addr [64];
	rv_core_pkg::word_t exp_data [64];
	int     exp_count = 0;
	int     test_id = 0;
	int     pc_n = 0;
	int     budget = 20;
	int     cycles = 0;
	integer seed;
	logic   test_done;
	int     tests_passed;
	int     tests_failed;
	int     errors;

	rv_core dut0 (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_addr  (imem_addr),
		.imem_rdata (imem_rdata),
		.dmem_re    (dmem_re),
		.dmem_we    (dmem_we),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_rdata (dmem_rdata)
	);

	rv_core_checker chk0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.dmem_we      (dmem_we),
		.dmem_addr    (dmem_addr),
		.dmem_wdata   (dmem_wdata),
		.done_addr    (DONE_ADDR),
		.exp_addr     (exp_addr),
		.exp_data     (exp_data),
		.exp_count    (exp_count),
		.test_id      (test_id),
		.test_done    (test_done),
		.tests_passed (tests_passed),
		.tests_failed (tests_failed),
		.errors       (errors)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ----------------------------------------
	// memories
	// ----------------------------------------
	function automatic rv_core_pkg::word_t fill_word(input int i);
		return 32'h3c00_0000 ^ (i * 32'h0001_0203);
	endfunction

	assign imem_rdata = imem[imem_addr[5:0]];
	// load data only while the core strobes a read
	assign dmem_rdata = dmem_re ? dmem[dmem_addr[7:2]] : '0;

	// refilled on every reset so each test starts from the same data
	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 64; i++)
				dmem[i] <= fill_word(i);
		end else if (dmem_we && dmem_addr[31:8] == '0) begin
			dmem[dmem_addr[7:2]] <= dmem_wdata;
		end
	end

	// ----------------------------------------
	// instruction encoders
	// ----------------------------------------
	function automatic rv_core_pkg::word_t enc_r(input logic [6:0] f7,
		input rv_core_pkg::reg_idx_t rs2, input rv_core_pkg::reg_idx_t rs1,
		input logic [2:0] f3, input rv_core_pkg::reg_idx_t rd);
		rv_core_pkg::instr_u w;
		w.r_fmt = '{f7, rs2, rs1, f3, rd, `RV_OP_REG};
		return w;
	endfunction

	function automatic rv_core_pkg::word_t enc_i(input logic [11:0] imm,
		input rv_core_pkg::reg_idx_t rs1, input logic [2:0] f3,
		input rv_core_pkg::reg_idx_t rd, input logic [6:0] op);
		rv_core_pkg::instr_u w;
		w.i_fmt = '{imm, rs1, f3, rd, op};
		return w;
	endfunction

	function automatic rv_core_pkg::word_t enc_s(input logic [11:0] imm,
		input rv_core_pkg::reg_idx_t rs2, input rv_core_pkg::reg_idx_t rs1);
		rv_core_pkg::instr_u w;
		w.s_fmt = '{imm[11:5], rs2, rs1, 3'b010, imm[4:0], `RV_OP_STORE};
		return w;
	endfunction

	function automatic rv_core_pkg::word_t enc_b(input logic [12:0] off,
		input rv_core_pkg::reg_idx_t rs2, input rv_core_pkg::reg_idx_t rs1,
		input logic [2:0] f3);
		rv_core_pkg::instr_u w;
		w.s_fmt = '{{off[12], off[10:5]}, rs2, rs1, f3, {off[4:1], off[11]}, `RV_OP_BRANCH};
		return w;
	endfunction

	function automatic rv_core_pkg::word_t enc_j(input logic [20:0] off,
		input rv_core_pkg::reg_idx_t rd);
		rv_core_pkg::instr_u w;
		w.j_fmt = '{off[20], off[10:1], off[11], off[19:12], rd, `RV_OP_JAL};
		return w;
	endfunction

	task automatic emit(input rv_core_pkg::word_t w);
		imem[pc_n] = w;
		pc_n++;
	endtask

	function automatic logic [11:0] rand_imm();
		return 12'($random(seed));
	endfunction

	// ----------------------------------------
	// program builder
	// ----------------------------------------
	task automatic build_program(input int t);
		for (int i = 0; i < 64; i++)
			imem[i] = '0;
		pc_n = 0;
		case (t)
			1: begin
				// x1 negative so slt sees a signed compare
				emit(enc_i(rand_imm() | 12'h800, 0, `RV_F3_ADD, 1, `RV_OP_IMM));
				emit(enc_i(rand_imm(), 0, `RV_F3_ADD, 2, `RV_OP_IMM));
				emit(enc_r(7'h00, 2, 1, `RV_F3_ADD, 3));
				emit(enc_r(7'h20, 2, 1, `RV_F3_ADD, 4));
				emit(enc_r(7'h00, 2, 1, `RV_F3_AND, 5));
				emit(enc_r(7'h00, 2, 1, `RV_F3_OR, 6));
				emit(enc_r(7'h00, 2, 1, `RV_F3_SLT, 7));
				emit(enc_r(7'h00, 1, 2, `RV_F3_SLT, 8));
				for (int i = 3; i <= 8; i++)
					emit(enc_s(12'(4 * (i - 3)), 5'(i), 0));
			end
			2: begin
				emit(enc_i(rand_imm(), 0, `RV_F3_ADD, 1, `RV_OP_IMM));
				emit(enc_r(7'h00, 1, 1, `RV_F3_ADD, 2));
				emit(enc_i(rand_imm(), 2, `RV_F3_ADD, 3, `RV_OP_IMM));
				emit(enc_r(7'h00, 3, 2, `RV_F3_ADD, 4));
				emit(enc_r(7'h20, 3, 4, `RV_F3_ADD, 5));
				emit(enc_s(12'd0, 5, 0));
				emit(enc_s(12'd4, 4, 0));
				emit(enc_s(12'd8, 2, 0));
			end
			3: begin
				emit(enc_i(12'd8, 0, 3'b010, 1, `RV_OP_LOAD));
				emit(enc_i(rand_imm(), 1, `RV_F3_ADD, 2, `RV_OP_IMM));
				emit(enc_s(12'd0, 2, 0));
				emit(enc_i(12'd12, 0, 3'b010, 3, `RV_OP_LOAD));
				emit(enc_s(12'd4, 3, 0));
				emit(enc_i(12'd16, 0, 3'b010, 4, `RV_OP_LOAD));
				emit(enc_r(7'h00, 4, 4, `RV_F3_ADD, 5));
				emit(enc_s(12'd8, 5, 0));
				emit(enc_i(12'd0, 0, 3'b010, 6, `RV_OP_LOAD));
				emit(enc_s(12'd12, 6, 0));
			end
			4: begin
				emit(enc_i(rand_imm(), 0, `RV_F3_ADD, 1, `RV_OP_IMM));
				emit(enc_i(rand_imm(), 0, `RV_F3_ADD, 2, `RV_OP_IMM));
				emit(enc_b(13'd8, 0, 2, `RV_F3_BNE));
				emit(enc_s(12'd0, 1, 0));
				emit(enc_b(13'd8, 1, 1, `RV_F3_BNE));
				emit(enc_s(12'd4, 2, 0));
				// x8 holds the same word that x3 loads right behind it
				emit(enc_i(12'd8, 0, 3'b010, 8, `RV_OP_LOAD));
				emit(enc_i(12'd8, 0, 3'b010, 3, `RV_OP_LOAD));
				emit(enc_b(13'd8, 8, 3, `RV_F3_BEQ));
				emit(enc_s(12'd12, 3, 0));
				emit(enc_r(7'h00, 0, 1, `RV_F3_ADD, 4));
				emit(enc_b(13'd8, 1, 4, `RV_F3_BEQ));
				emit(enc_s(12'd16, 4, 0));
				emit(enc_b(13'd8, 2, 1, `RV_F3_BEQ));
				emit(enc_s(12'd20, 1, 0));
			end
			5: begin
				emit(enc_i(rand_imm(), 0, `RV_F3_ADD, 1, `RV_OP_IMM));
				emit(enc_j(21'd8, 5));
				emit(enc_s(12'd0, 1, 0));
				emit(enc_s(12'd4, 5, 0));
				emit(enc_i(rand_imm(), 5, `RV_F3_ADD, 6, `RV_OP_IMM));
				emit(enc_s(12'd8, 6, 0));
				emit(enc_j(21'd12, 7));
				emit(enc_s(12'd16, 1, 0));
				emit(enc_s(12'd20, 1, 0));
				emit(enc_s(12'd24, 7, 0));
			end
			default: begin
				emit(enc_i(rand_imm(), 0, `RV_F3_ADD, 0, `RV_OP_IMM));
				emit(enc_r(7'h00, 0, 0, `RV_F3_ADD, 1));
				emit(enc_s(12'd0, 0, 0));
				emit(enc_s(12'd4, 1, 0));
				emit(enc_i(rand_imm(), 0, `RV_F3_ADD, 2, `RV_OP_IMM));
				emit(enc_r(7'h00, 2, 2, `RV_F3_ADD, 0));
				emit(enc_s(12'd8, 0, 0));
				emit(enc_s(12'd12, 2, 0));
			end
		endcase
		// done store, then spin in place
		emit(enc_s(DONE_ADDR[11:0], 1, 0));
		emit(enc_j(21'd0, 0));
	endtask

	// ----------------------------------------
	// architectural reference
	// ----------------------------------------
	function automatic int run_reference();
		rv_core_pkg::word_t regs [32];
		rv_core_pkg::word_t mem [64];
		rv_core_pkg::word_t pc;
		rv_core_pkg::word_t next_pc;
		rv_core_pkg::word_t a;
		rv_core_pkg::word_t b;
		rv_core_pkg::word_t val;
		rv_core_pkg::word_t ea;
		rv_core_pkg::instr_u ins;
		int n;
		logic wr;
		for (int i = 0; i < 64; i++)
			mem[i] = fill_word(i);
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
		pc = '0;
		n = 0;
		for (int step = 0; step < 1000; step++) begin
			ins = imem[pc[7:2]];
			a = regs[ins.r_fmt.rs1];
			b = regs[ins.r_fmt.rs2];
			next_pc = pc + 4;
			wr = 1'b1;
			val = '0;
			if (ins.r_fmt.opcode == `RV_OP_IMM)
				b = {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
			case (ins.r_fmt.opcode)
				`RV_OP_REG, `RV_OP_IMM: begin
					case (ins.r_fmt.funct3)
						`RV_F3_SLT: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						`RV_F3_OR:  val = a | b;
						`RV_F3_AND: val = a & b;
						default: begin
							if (ins.r_fmt.opcode == `RV_OP_REG && ins.r_fmt.funct7[5])
								val = a - b;
							else
								val = a + b;
						end
					endcase
				end
				`RV_OP_LOAD: begin
					ea = a + {{20{ins.i_fmt.imm[11]}}, ins.i_fmt.imm};
					val = mem[ea[7:2]];
				end
				`RV_OP_STORE: begin
					wr = 1'b0;
					ea = a + {{20{ins.s_fmt.imm_hi[6]}}, ins.s_fmt.imm_hi, ins.s_fmt.imm_lo};
					exp_addr[n] = ea;
					exp_data[n] = b;
					n++;
					if (ea == DONE_ADDR)
						return n;
					if (ea[31:8] == '0)
						mem[ea[7:2]] = b;
				end
				`RV_OP_BRANCH: begin
					wr = 1'b0;
					if ((ins.s_fmt.funct3 == `RV_F3_BEQ && a == b) ||
						(ins.s_fmt.funct3 == `RV_F3_BNE && a != b))
						next_pc = pc + {{20{ins.s_fmt.imm_hi[6]}}, ins.s_fmt.imm_lo[0],
							ins.s_fmt.imm_hi[5:0], ins.s_fmt.imm_lo[4:1], 1'b0};
				end
				`RV_OP_JAL: begin
					val = pc + 4;
					next_pc = pc + {{12{ins.j_fmt.imm_20}}, ins.j_fmt.imm_19_12,
						ins.j_fmt.imm_11, ins.j_fmt.imm_10_1, 1'b0};
				end
				default: wr = 1'b0;
			endcase
			if (wr)
				regs[ins.r_fmt.rd] = val;
			regs[0] = '0;
			pc = next_pc;
		end
		return n;
	endfunction

	// ----------------------------------------
	// sequencing and watchdog
	// ----------------------------------------
	initial begin
		seed = 32'hb2df;
		for (int i = 0; i < 64; i++)
			imem[i] = '0;
		for (int t = 1; t <= NUM_TESTS; t++) begin
			@(posedge clk);
			rst_n   <= 1'b0;
			test_id <= t;
			repeat (5) @(posedge clk);
			// new program goes in while the core is still held in reset
			build_program(t);
			exp_count = run_reference();
			budget += pc_n * 6 + 10;
			rst_n <= 1'b1;
			wait (test_done);
			repeat (2) @(posedge clk);
		end
		$display("tests passed %0d, failed %0d, errors %0d",
			tests_passed, tests_failed, errors);
		if (tests_passed == NUM_TESTS && tests_failed == 0 && errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// budget grows with each program that is built
	initial begin
		while (cycles <= budget) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: done store not seen within %0d cycles", budget);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// File: src.f
+incdir+verilog
verilog/rv_core_pkg.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/hazard_forward.sv
verilog/execute_stage.sv
verilog/rv_core.sv
verification/rv_core_checker.sv
verification/rv_core_props.sv
verification/rv_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := rv_core_tb
FILELIST  := src.f
FLAGS     := --binary --timing --assert --top-module $(TOP)
BUILD     := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log for the pass line"
	@echo "  clean  remove build output and log"

test:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST PASS" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
